/* dsp_core.f */
+incdir+logic
+incdir+bench
logic/dsp_pkg.sv
logic/insn_sequencer.sv
logic/program_fetch.sv
logic/register_file.sv
logic/alu_flags.sv
logic/host_port.sv
logic/dsp_core.sv
bench/dsp_core_tb.sv

/* bench/dsp_tests.svh */
`ifndef DSP_TESTS_SVH
`define DSP_TESTS_SVH

task automatic test_ld_dr;
  dsp_word_t  value;
  dsp_word_t  got;
  logic [7:0] status;
  value = dsp_word_t'($random(seed));
  prog.delete();
  prog.push_back(ld_insn(value, `DSP_DST_DR));
  prog.push_back(jp_insn(BR_JMP, 11'd1));
  run_program();
  wait_rqm();
  read_status(status);
  check_status("test_ld_dr rqm set", 8'h80, status);
  host_read_dr(got);
  check_word("test_ld_dr", value, got);
  read_status(status);
  check_status("test_ld_dr rqm clear", 8'h00, status); // second byte drops RQM
endtask

task automatic test_alu_ops;
  logic [3:0] ops [6];
  dsp_word_t  a;
  dsp_word_t  t;
  dsp_word_t  expected;
  dsp_word_t  got;
  ops = '{4'h5, 4'h4, 4'h2, 4'h1, 4'h3, 4'hb}; // add sub and or xor shr
  foreach (ops[i]) begin
    a = dsp_word_t'($random(seed));
    t = dsp_word_t'($random(seed));
    case (ops[i])
      4'h5:    expected = a + t;
      4'h4:    expected = a - t;
      4'h2:    expected = a & t;
      4'h1:    expected = a | t;
      4'h3:    expected = a ^ t;
      default: expected = dsp_word_t'($signed(a) >>> 1);
    endcase
    prog.delete();
    prog.push_back(ld_insn(a, DST_A));
    prog.push_back(ld_insn(t, DST_TR));
    prog.push_back(op_insn(2'b01, ops[i], 1'b0, 2'b00, SRC_TR, 4'h0));
    prog.push_back(op_insn(2'b00, 4'h0, 1'b0, 2'b00, SRC_A, `DSP_DST_DR));
    prog.push_back(jp_insn(BR_JMP, 11'd4));
    run_program();
    wait_rqm();
    host_read_dr(got);
    check_word($sformatf("test_alu_ops alu %h", ops[i]), expected, got);
  end
endtask

task automatic test_multiply;
  dsp_word_t          k;
  dsp_word_t          l;
  dsp_word_t          got;
  logic signed [31:0] product;
  k = dsp_word_t'($random(seed));
  l = dsp_word_t'($random(seed));
  product = $signed(k) * $signed(l);
  prog.delete();
  prog.push_back(ld_insn(k, DST_K));
  prog.push_back(ld_insn(l, DST_L));
  prog.push_back(op_insn(2'b10, 4'h5, 1'b0, 2'b00, 4'h0, 4'h0)); // A = 0 + M
  prog.push_back(op_insn(2'b00, 4'h0, 1'b0, 2'b00, SRC_A, `DSP_DST_DR));
  prog.push_back(jp_insn(BR_JMP, 11'd4));
  run_program();
  wait_rqm();
  host_read_dr(got);
  check_word("test_multiply", {product[31], product[29:15]}, got);
endtask

task automatic test_host_echo;
  dsp_word_t w;
  dsp_word_t got;
  w = dsp_word_t'($random(seed));
  prog.delete();
  prog.push_back(op_insn(2'b00, 4'h0, 1'b0, 2'b00, `DSP_SRC_DR, 4'h0)); // ask for data
  prog.push_back(jp_insn(BR_RQM_SET, 11'd1));
  prog.push_back(op_insn(2'b00, 4'h0, 1'b0, 2'b00, SRC_DR_NF, DST_A));
  prog.push_back(op_insn(2'b00, 4'h9, 1'b0, 2'b00, 4'h0, 4'h0)); // inc A
  prog.push_back(op_insn(2'b00, 4'h0, 1'b0, 2'b00, SRC_A, `DSP_DST_DR));
  prog.push_back(jp_insn(BR_JMP, 11'd5));
  run_program();
  wait_rqm();
  host_write_dr(w);
  wait_rqm();
  host_read_dr(got);
  check_word("test_host_echo", w + 16'd1, got);
endtask

task automatic test_branch_call;
  dsp_word_t v;
  dsp_word_t m1;
  dsp_word_t m2;
  dsp_word_t got;
  v  = dsp_word_t'($random(seed));
  m1 = dsp_word_t'($random(seed));
  m2 = dsp_word_t'($random(seed));
  prog.delete();
  prog.push_back(ld_insn(v, DST_A));
  prog.push_back(ld_insn(v, DST_TR));
  prog.push_back(op_insn(2'b01, 4'h4, 1'b0, 2'b00, SRC_TR, 4'h0)); // A - TR sets Z
  prog.push_back(jp_insn(BR_Z_SET, 11'd5));
  prog.push_back(ld_insn(~m1, `DSP_DST_DR)); // skipped marker
  prog.push_back(jp_insn(BR_RQM_SET, 11'd5));
  prog.push_back(jp_insn(BR_CALL, 11'd10));
  prog.push_back(ld_insn(m2, `DSP_DST_DR)); // return lands here
  prog.push_back(jp_insn(BR_JMP, 11'd8));
  prog.push_back(jp_insn(BR_JMP, 11'd9));
  prog.push_back(ld_insn(m1, `DSP_DST_DR)); // subroutine
  prog.push_back(jp_insn(BR_RQM_SET, 11'd11));
  prog.push_back(rt_insn());
  run_program();
  wait_rqm();
  host_read_dr(got);
  check_word("test_branch_call first marker", m1, got);
  wait_rqm();
  host_read_dr(got);
  check_word("test_branch_call second marker", m2, got);
endtask

task automatic test_data_ram;
  dsp_word_t w1;
  dsp_word_t w2;
  dsp_word_t got;
  w1 = dsp_word_t'($random(seed));
  w2 = dsp_word_t'($random(seed));
  prog.delete();
  prog.push_back(ld_insn(w1, DST_RAM));
  prog.push_back(op_insn(2'b00, 4'h0, 1'b0, 2'b01, 4'h0, 4'h0)); // DP low + 1
  prog.push_back(ld_insn(w2, DST_RAM));
  prog.push_back(op_insn(2'b00, 4'h0, 1'b0, 2'b11, 4'h0, 4'h0)); // DP low cleared
  prog.push_back(op_insn(2'b00, 4'h0, 1'b0, 2'b01, SRC_RAM, `DSP_DST_DR));
  prog.push_back(jp_insn(BR_RQM_SET, 11'd5));
  prog.push_back(op_insn(2'b00, 4'h0, 1'b0, 2'b00, SRC_RAM, `DSP_DST_DR));
  prog.push_back(jp_insn(BR_JMP, 11'd7));
  run_program();
  wait_rqm();
  host_read_dr(got);
  check_word("test_data_ram word 0", w1, got);
  wait_rqm();
  host_read_dr(got);
  check_word("test_data_ram word 1", w2, got);
endtask

`endif

/* bench/dsp_core_tb.sv */
`include "dsp_params.svh"

module dsp_core_tb import dsp_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD      = 10;
  localparam int TEST_COUNT      = 6;
  localparam int CYCLES_PER_TEST = 400;

  // branch codes, bits 8:0 of the JP word
  localparam logic [8:0] BR_JMP     = 9'b100_000_000;
  localparam logic [8:0] BR_CALL    = 9'b101_000_000;
  localparam logic [8:0] BR_Z_SET   = 9'b010_001_010; // bank A
  localparam logic [8:0] BR_RQM_SET = 9'b010_111_110;

  localparam logic [3:0] SRC_A     = 4'b0001;
  localparam logic [3:0] SRC_TR    = 4'b0011;
  localparam logic [3:0] SRC_DR_NF = 4'b1001; // DR read without request
  localparam logic [3:0] SRC_RAM   = 4'b1111;
  localparam logic [3:0] DST_A     = 4'b0001;
  localparam logic [3:0] DST_TR    = 4'b0011;
  localparam logic [3:0] DST_K     = 4'b1010;
  localparam logic [3:0] DST_L     = 4'b1101;
  localparam logic [3:0] DST_RAM   = 4'b1111;

  logic                   CLK;
  logic                   RST;
  host_bus_t              host;
  logic [7:0]             rd_data;
  logic                   pgm_wr;
  pc_t                    pgm_addr;
  logic [`DSP_INSN_W-1:0] pgm_data;
  integer                 seed;
  opcode_u                prog [$];

  dsp_core u_dsp_core (
    .CLK(CLK), .RST(RST), .host(host), .rd_data(rd_data),
    .pgm_wr(pgm_wr), .pgm_addr(pgm_addr), .pgm_data(pgm_data)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
    $display("run timed out waiting for the DUT");
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////
  // instruction encoders
  function automatic opcode_u op_insn(input logic [1:0] psel, input logic [3:0] alu,
                                      input logic asl, input logic [1:0] dpl,
                                      input logic [3:0] src, input logic [3:0] dst);
    opcode_u w;
    w         = '0;
    w.op.cls  = `DSP_CLS_OP;
    w.op.psel = psel;
    w.op.alu  = alu;
    w.op.asl  = asl;
    w.op.dpl  = dpl;
    w.op.src  = src;
    w.op.dst  = dst;
    return w;
  endfunction

  function automatic opcode_u rt_insn();
    opcode_u w;
    w        = '0;
    w.op.cls = `DSP_CLS_RT; // plain return, ALU nop
    return w;
  endfunction

  function automatic opcode_u jp_insn(input logic [8:0] brch, input pc_t na);
    opcode_u w;
    w         = '0;
    w.jp.cls  = `DSP_CLS_JP;
    w.jp.brch = brch;
    w.jp.na   = na;
    return w;
  endfunction

  function automatic opcode_u ld_insn(input dsp_word_t imm, input logic [3:0] dst);
    opcode_u w;
    w        = '0;
    w.ld.cls = `DSP_CLS_LD;
    w.ld.imm = imm;
    w.ld.dst = dst;
    return w;
  endfunction

  //////////////////////////////
  // program load and host bus
  task automatic run_program;
    @(posedge CLK);
    RST <= 1'b1;
    for (int i = 0; i < prog.size(); i++) begin
      @(posedge CLK);
      pgm_wr   <= 1'b1;
      pgm_addr <= pc_t'(i);
      pgm_data <= prog[i];
    end
    @(posedge CLK);
    pgm_wr <= 1'b0;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;
  endtask

  task automatic host_access(input logic wr, input logic rd, input logic a0,
                             input logic [7:0] wdata, output logic [7:0] rdata);
    host_bus_t req;
    req.wr    = wr;
    req.rd    = rd;
    req.a0    = a0;
    req.wdata = wdata;
    @(posedge CLK);
    host <= req;
    @(negedge CLK);
    rdata = rd_data; // before the strobe edge moves DRS
    @(posedge CLK);
    host <= '0;
  endtask

  task automatic read_status(output logic [7:0] status);
    host_access(1'b0, 1'b1, 1'b1, 8'h00, status);
  endtask

  task automatic wait_rqm;
    logic [7:0] status;
    status = '0;
    while (!status[7]) begin
      read_status(status);
    end
  endtask

  task automatic host_write_dr(input dsp_word_t w);
    logic [7:0] unused;
    host_access(1'b1, 1'b0, 1'b0, w[7:0], unused);
    host_access(1'b1, 1'b0, 1'b0, w[15:8], unused);
  endtask

  task automatic host_read_dr(output dsp_word_t w);
    logic [7:0] lo;
    logic [7:0] hi;
    host_access(1'b0, 1'b1, 1'b0, 8'h00, lo);
    host_access(1'b0, 1'b1, 1'b0, 8'h00, hi);
    w = {hi, lo};
  endtask

  //////////////////////////////
  // compare tasks
  task automatic check_word(input string name, input dsp_word_t expected,
                            input dsp_word_t actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_status(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  `include "dsp_tests.svh"

  initial begin
    RST      = 1'b1;
    host     = '0;
    pgm_wr   = 1'b0;
    pgm_addr = '0;
    pgm_data = '0;
    seed     = 89488;
    test_ld_dr();
    test_alu_ops();
    test_multiply();
    test_host_echo();
    test_branch_call();
    test_data_ram();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* logic/dsp_core.sv */
`include "dsp_params.svh"

module dsp_core import dsp_pkg::*; (
  input  logic                   CLK,
  input  logic                   RST,
  input  host_bus_t              host,
  output logic [7:0]             rd_data,
  input  logic                   pgm_wr,
  input  pc_t                    pgm_addr,
  input  logic [`DSP_INSN_W-1:0] pgm_data
);

  opcode_u    opcode;
  opcode_u    insn;
  phase_t     phase;
  dsp_word_t  idb;
  dsp_word_t  m_word;
  dsp_word_t  n_word;
  dsp_word_t  ram_word;
  dsp_word_t  acc_a;
  dsp_word_t  acc_b;
  dsp_word_t  load_word;
  dsp_word_t  dr;
  flag_bank_t flags_a;
  flag_bank_t flags_b;
  logic [3:0] dpl;
  logic [1:0] acc_load;
  logic       rqm;

  insn_sequencer u_seq (
    .CLK(CLK), .RST(RST), .opcode(opcode), .insn(insn), .phase(phase), .state()
  );

  program_fetch u_fetch (
    .CLK(CLK), .RST(RST), .pgm_wr(pgm_wr), .pgm_addr(pgm_addr), .pgm_data(pgm_data),
    .insn(insn), .phase(phase), .flags_a(flags_a), .flags_b(flags_b), .dpl(dpl),
    .rqm(rqm), .opcode(opcode)
  );

  register_file u_regs (
    .CLK(CLK), .RST(RST), .insn(insn), .phase(phase), .acc_a(acc_a), .acc_b(acc_b),
    .flags_a(flags_a), .dr(dr), .idb(idb), .m_word(m_word), .n_word(n_word),
    .ram_word(ram_word), .dpl(dpl), .acc_load(acc_load), .load_word(load_word)
  );

  alu_flags u_alu (
    .CLK(CLK), .RST(RST), .insn(insn), .phase(phase), .idb(idb), .m_word(m_word),
    .n_word(n_word), .ram_word(ram_word), .acc_load(acc_load), .load_word(load_word),
    .acc_a(acc_a), .acc_b(acc_b), .flags_a(flags_a), .flags_b(flags_b)
  );

  host_port u_host (
    .CLK(CLK), .RST(RST), .host(host), .insn(insn), .phase(phase), .idb(idb),
    .rd_data(rd_data), .dr(dr), .rqm(rqm)
  );

endmodule

/* logic/host_port.sv */
`include "dsp_params.svh"

module host_port import dsp_pkg::*; (
  input  logic       CLK,
  input  logic       RST,
  input  host_bus_t  host,
  input  opcode_u    insn,
  input  phase_t     phase,
  input  dsp_word_t  idb,
  output logic [7:0] rd_data,
  output dsp_word_t  dr,
  output logic       rqm
);

  dsp_word_t sr;
  logic      drs;       // 1 = next DR byte is the high one
  logic      dr_access;
  logic      dr_dst;
  logic      dr_src;

  assign dr_access = (host.wr | host.rd) & ~host.a0;
  assign dr_dst    = (insn.op.cls != `DSP_CLS_JP) && (insn.op.dst == `DSP_DST_DR);
  assign dr_src    = ~insn.op.cls[1] && (insn.op.src == `DSP_SRC_DR);

  //////////////////////////////
  // handshake
  always_ff @(posedge CLK) begin
    if (RST) begin
      drs <= 1'b0;
      rqm <= 1'b0;
    end else if (dr_access) begin
      drs <= ~drs;
      if (drs) begin
        rqm <= 1'b0; // second byte done
      end
    end else if (phase.store && (dr_dst || dr_src)) begin
      rqm <= 1'b1;
    end
  end

  // LD immediates also arrive on idb
  always_ff @(posedge CLK) begin
    if (host.wr && !host.a0) begin
      if (drs) begin
        dr[15:8] <= host.wdata;
      end else begin
        dr[7:0] <= host.wdata;
      end
    end else if (phase.store && dr_dst) begin
      dr <= idb;
    end
  end

  always_comb begin
    sr              = '0;
    sr[`DSP_SR_RQM] = rqm;
    sr[`DSP_SR_DRS] = drs;
  end

  assign rd_data = host.a0 ? sr[15:8] : (drs ? dr[15:8] : dr[7:0]);

  // a core request for RQM never lands on a host DR access
  a_rqm_quiet: assert property (@(posedge CLK) disable iff (RST)
    dr_access |-> !(phase.store && (dr_dst || dr_src)));

endmodule

/* logic/alu_flags.sv */
module alu_flags import dsp_pkg::*; (
  input  logic       CLK,
  input  logic       RST,
  input  opcode_u    insn,
  input  phase_t     phase,
  input  dsp_word_t  idb,
  input  dsp_word_t  m_word,
  input  dsp_word_t  n_word,
  input  dsp_word_t  ram_word,
  input  logic [1:0] acc_load,
  input  dsp_word_t  load_word,
  output dsp_word_t  acc_a,
  output dsp_word_t  acc_b,
  output flag_bank_t flags_a,
  output flag_bank_t flags_b
);

  dsp_word_t  acc [2];
  flag_bank_t flags [2];
  flag_bank_t flag_next;
  dsp_word_t  p;
  dsp_word_t  q;
  dsp_word_t  r;
  logic [1:0] loaded; // bus wrote this acc in the current instruction
  logic       alu_cls;
  logic       asl;
  logic       cin;
  logic       ovf;

  assign alu_cls = ~insn.op.cls[1]; // OP and RT
  assign asl     = insn.op.asl;
  assign cin     = flags[!asl].c;   // carry from the other bank
  assign acc_a   = acc[0];
  assign acc_b   = acc[1];
  assign flags_a = flags[0];
  assign flags_b = flags[1];

  //////////////////////////////
  // operands and result
  always_ff @(posedge CLK) begin
    if (phase.alu1 && alu_cls) begin
      q <= acc[asl];
      if (insn.op.alu[3:1] == 3'b100) begin
        p <= dsp_word_t'(1); // inc / dec
      end else begin
        case (insn.op.psel)
          2'b00:   p <= ram_word;
          2'b01:   p <= idb;
          2'b10:   p <= m_word;
          default: p <= n_word;
        endcase
      end
    end
    if (phase.store) begin
      case (insn.op.alu)
        4'h1:       r <= q | p;
        4'h2:       r <= q & p;
        4'h3:       r <= q ^ p;
        4'h4, 4'h8: r <= q - p;
        4'h5, 4'h9: r <= q + p;
        4'h6:       r <= q - p - cin;
        4'h7:       r <= q + p + cin;
        4'ha:       r <= ~q;
        4'hb:       r <= {q[15], q[15:1]};
        4'hc:       r <= {q[14:0], cin};
        4'hd:       r <= {q[13:0], 2'b11};
        4'he:       r <= {q[11:0], 4'hf};
        4'hf:       r <= {q[7:0], q[15:8]};
        default:    r <= q;
      endcase
    end
  end

  always_comb begin
    flag_next    = flags[asl];
    flag_next.z  = (r == '0);
    flag_next.s0 = r[15];
    if (insn.op.alu[0]) begin
      ovf = (q[15] ^ r[15]) & ~(q[15] ^ p[15]); // add
    end else begin
      ovf = (q[15] ^ r[15]) & (q[15] ^ p[15]);
    end
    flag_next.ov0 = 1'b0;
    flag_next.c   = 1'b0;
    case (insn.op.alu)
      4'h4, 4'h5, 4'h6, 4'h7, 4'h8, 4'h9: begin
        flag_next.c   = insn.op.alu[0] ? (r < q) : (r > q);
        flag_next.ov0 = ovf;
        if (ovf) begin
          flag_next.s1  = flags[asl].ov1 ^ ~r[15];
          flag_next.ov1 = ~flags[asl].ov1;
        end
      end
      4'hb: begin
        flag_next.c   = q[0];
        flag_next.ov1 = 1'b0;
      end
      4'hc: begin
        flag_next.c   = q[15];
        flag_next.ov1 = 1'b0;
      end
      default: flag_next.ov1 = 1'b0; // logic ops
    endcase
  end

  //////////////////////////////
  // accumulators and flag banks
  always_ff @(posedge CLK) begin
    if (RST) begin
      acc[0]   <= '0;
      acc[1]   <= '0;
      flags[0] <= '0;
      flags[1] <= '0;
      loaded   <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (acc_load[i]) begin
          acc[i]    <= load_word;
          loaded[i] <= 1'b1;
        end
      end
      if (phase.idle) begin
        loaded <= '0;
        if (alu_cls && (insn.op.alu != 4'h0) && !loaded[asl]) begin
          acc[asl] <= r;
        end
      end
      // insn still holds the previous instruction here
      if (phase.fetch && alu_cls && (insn.op.alu != 4'h0)) begin
        flags[asl] <= flag_next;
      end
    end
  end

endmodule

/* logic/register_file.sv */
`include "dsp_params.svh"

module register_file import dsp_pkg::*; (
  input  logic       CLK,
  input  logic       RST,
  input  opcode_u    insn,
  input  phase_t     phase,
  input  dsp_word_t  acc_a,
  input  dsp_word_t  acc_b,
  input  flag_bank_t flags_a,
  input  dsp_word_t  dr,
  output dsp_word_t  idb,
  output dsp_word_t  m_word,
  output dsp_word_t  n_word,
  output dsp_word_t  ram_word,
  output logic [3:0] dpl,
  output logic [1:0] acc_load,
  output dsp_word_t  load_word
);

  localparam int RAM_DEPTH = 2 ** `DSP_RAM_AW;

  dsp_word_t ram [RAM_DEPTH];
  dsp_word_t tr;
  dsp_word_t trb;
  dsp_word_t k;
  dsp_word_t l;
  logic [`DSP_RAM_AW-1:0] dp;
  logic [`DSP_RAM_AW-1:0] ram_addr;
  logic signed [2*`DSP_WORD_W-1:0] product;
  logic src_alu;
  logic dst_wr;
  logic k_from_ram;

  assign src_alu    = (insn.op.cls == `DSP_CLS_OP) || (insn.op.cls == `DSP_CLS_RT);
  assign dst_wr     = phase.store && (insn.op.cls != `DSP_CLS_JP);
  assign k_from_ram = dst_wr && (insn.op.dst == 4'b1100);

  // K load from ram reads the upper half of the page
  always_comb begin
    ram_addr = dp;
    if (k_from_ram) begin
      ram_addr[6] = 1'b1;
    end
  end

  assign ram_word  = ram[ram_addr];
  assign dpl       = dp[3:0];
  assign product   = $signed(k) * $signed(l);
  assign load_word = idb;
  assign acc_load[0] = dst_wr && (insn.op.dst == 4'b0001);
  assign acc_load[1] = dst_wr && (insn.op.dst == 4'b0010);

  //////////////////////////////
  // internal data bus
  always_ff @(posedge CLK) begin
    if (phase.load) begin
      if (insn.ld.cls == `DSP_CLS_LD) begin
        idb <= insn.ld.imm;
      end else if (src_alu) begin
        case (insn.op.src)
          4'b0000: idb <= trb;
          4'b0001: idb <= acc_a;
          4'b0010: idb <= acc_b;
          4'b0011: idb <= tr;
          4'b0100: idb <= dsp_word_t'(dp);
          4'b0111: idb <= flags_a.s1 ? 16'h7fff : 16'h8000; // saturation value
          4'b1000, 4'b1001: idb <= dr;
          4'b1101: idb <= k;
          4'b1110: idb <= l;
          4'b1111: idb <= ram_word;
          default: idb <= '0;
        endcase
      end
    end
  end

  //////////////////////////////
  // destinations and DP
  always_ff @(posedge CLK) begin
    if (RST) begin
      tr  <= '0;
      trb <= '0;
      k   <= '0;
      l   <= '0;
      dp  <= '0;
    end else begin
      if (dst_wr) begin
        case (insn.op.dst)
          4'b0011: tr <= idb;
          4'b0100: dp <= idb[`DSP_RAM_AW-1:0];
          4'b1010: k <= idb;
          4'b1100: begin
            k <= ram_word;
            l <= idb;
          end
          4'b1101: l <= idb;
          4'b1110: trb <= idb;
          default: ;
        endcase
      end
      if (phase.idle && src_alu) begin
        case (insn.op.dpl)
          2'b01:   dp[3:0] <= dp[3:0] + 1'b1;
          2'b10:   dp[3:0] <= dp[3:0] - 1'b1;
          2'b11:   dp[3:0] <= 4'h0;
          default: ;
        endcase
        dp[`DSP_RAM_AW-1:4] <= dp[`DSP_RAM_AW-1:4] ^ insn.op.dphm;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (dst_wr && (insn.op.dst == 4'b1111)) begin
      ram[dp] <= idb;
    end
  end

  // M keeps the sign and drops the duplicated sign bit
  always_ff @(posedge CLK) begin
    if (phase.fetch) begin
      m_word <= {product[31], product[29:15]};
      n_word <= {product[14:0], 1'b0};
    end
  end

endmodule

/* logic/program_fetch.sv */
`include "dsp_params.svh"

module program_fetch import dsp_pkg::*; (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   pgm_wr,
  input  pc_t                    pgm_addr,
  input  logic [`DSP_INSN_W-1:0] pgm_data,
  input  opcode_u                insn,
  input  phase_t                 phase,
  input  flag_bank_t             flags_a,
  input  flag_bank_t             flags_b,
  input  logic [3:0]             dpl,
  input  logic                   rqm,
  output opcode_u                opcode
);

  localparam int SP_W = $clog2(`DSP_STACK_DEPTH) + 1; // extra bit tells full from empty

  logic [`DSP_INSN_W-1:0] pgm_mem [2 ** `DSP_PC_W];
  pc_t             stack [`DSP_STACK_DEPTH];
  pc_t             pc;
  pc_t             pc_inc;
  logic [SP_W-1:0] sp;
  logic [SP_W-2:0] sp_top;
  flag_bank_t      fb;
  logic            cond_bit;
  logic            take;
  logic            push;
  logic            pop;

  assign pc_inc = pc + 1'b1;
  assign sp_top = sp[SP_W-2:0] - 1'b1;
  assign push   = phase.store && (insn.jp.cls == `DSP_CLS_JP) && take &&
                  (insn.jp.brch[8:6] == 3'b101);
  assign pop    = phase.store && (insn.op.cls == `DSP_CLS_RT);

  always_ff @(posedge CLK) begin
    if (pgm_wr) begin
      pgm_mem[pgm_addr] <= pgm_data;
    end
    opcode <= pgm_mem[pc]; // one cycle read
  end

  //////////////////////////////
  // branch condition
  always_comb begin
    fb = insn.jp.brch[2] ? flags_b : flags_a;
    case (insn.jp.brch[5:3])
      3'b000:  cond_bit = fb.c;
      3'b001:  cond_bit = fb.z;
      3'b010:  cond_bit = fb.ov0;
      3'b011:  cond_bit = fb.ov1;
      3'b100:  cond_bit = fb.s0;
      3'b101:  cond_bit = fb.s1;
      3'b110:  cond_bit = insn.jp.brch[1] ? (dpl == 4'hf) : (dpl == 4'h0);
      default: cond_bit = rqm;
    endcase
    case (insn.jp.brch[8:6])
      3'b100, 3'b101: take = (insn.jp.brch[5:0] == '0); // jmp, call
      3'b010: begin
        if (insn.jp.brch[5:3] == 3'b110) begin
          take = !insn.jp.brch[2] && (cond_bit ^ insn.jp.brch[0]); // bit 0 inverts
        end else if (insn.jp.brch[5:3] == 3'b111) begin
          take = insn.jp.brch[2] && !insn.jp.brch[0] && (cond_bit == insn.jp.brch[1]);
        end else begin
          take = !insn.jp.brch[0] && (cond_bit == insn.jp.brch[1]);
        end
      end
      default: take = 1'b0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      pc <= '0;
      sp <= '0;
    end else if (phase.store) begin
      case (insn.op.cls)
        `DSP_CLS_RT: pc <= stack[sp_top];
        `DSP_CLS_JP: pc <= take ? insn.jp.na : pc_inc;
        default:     pc <= pc_inc;
      endcase
      if (push) begin
        sp <= sp + 1'b1;
      end else if (pop) begin
        sp <= sp - 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      stack[sp[SP_W-2:0]] <= pc_inc; // return address
    end
  end

  a_no_overflow: assert property (@(posedge CLK) disable iff (RST)
    push |-> (sp < `DSP_STACK_DEPTH));
  a_no_underflow: assert property (@(posedge CLK) disable iff (RST)
    pop |-> (sp != '0));

endmodule

/* logic/insn_sequencer.sv */
module insn_sequencer import dsp_pkg::*; (
  input  logic       CLK,
  input  logic       RST,
  input  opcode_u    opcode,
  output opcode_u    insn,
  output phase_t     phase,
  output seq_state_e state
);

  //////////////////////////////
  // seven cycle instruction loop
  always_ff @(posedge CLK) begin
    if (RST) begin
      state <= IDLE;
      insn  <= '0; // OP nop, touches nothing
    end else begin
      case (state)
        IDLE:    state <= FETCH;
        FETCH:   state <= LOAD;
        LOAD:    state <= ALU1;
        ALU1:    state <= ALU2;
        ALU2:    state <= STORE;
        STORE:   state <= NEXT;
        default: state <= IDLE;
      endcase
      if (state == FETCH) begin
        insn <= opcode;
      end
    end
  end

  // ALU2 is a wait slot with no strobe
  always_comb begin
    phase       = '0;
    phase.fetch = (state == FETCH);
    phase.load  = (state == LOAD);
    phase.alu1  = (state == ALU1);
    phase.store = (state == STORE);
    phase.next  = (state == NEXT);
    phase.idle  = (state == IDLE);
  end

  a_one_phase: assert property (@(posedge CLK) disable iff (RST)
    (state == ALU2) ? (phase == '0) : $onehot(phase));

endmodule

/* logic/dsp_pkg.sv */
`include "dsp_params.svh"

package dsp_pkg;

  typedef logic [`DSP_WORD_W-1:0] dsp_word_t;
  typedef logic [`DSP_PC_W-1:0]   pc_t;

  // OP and RT layout
  typedef struct packed {
    logic [1:0] cls;
    logic [1:0] psel;   // P source: ram, idb, m, n
    logic [3:0] alu;
    logic       asl;    // 0 = acc A, 1 = acc B
    logic [1:0] dpl;    // nop, inc, dec, clear
    logic [3:0] dphm;   // xor mask on DP high
    logic       rpdcr;
    logic [3:0] src;
    logic [3:0] dst;
  } op_fields_t;

  typedef struct packed {
    logic [1:0] cls;
    logic [8:0] brch;
    pc_t        na;     // jump target
    logic [1:0] spare;
  } jp_fields_t;

  typedef struct packed {
    logic [1:0] cls;
    dsp_word_t  imm;
    logic [1:0] spare;
    logic [3:0] dst;    // same position as in op_fields_t
  } ld_fields_t;

  typedef union packed {
    op_fields_t op;
    jp_fields_t jp;
    ld_fields_t ld;
  } opcode_u;

  typedef struct packed {
    logic s1;
    logic s0;
    logic c;
    logic z;
    logic ov1;
    logic ov0;
  } flag_bank_t;

  // one host access, strobes are a single cycle wide
  typedef struct packed {
    logic       wr;
    logic       rd;
    logic       a0;
    logic [7:0] wdata;
  } host_bus_t;

  typedef enum logic [2:0] {FETCH, LOAD, ALU1, ALU2, STORE, NEXT, IDLE} seq_state_e;

  typedef struct packed {
    logic fetch;
    logic load;
    logic alu1;
    logic store;
    logic next;
    logic idle;
  } phase_t;

endpackage

/* logic/dsp_params.svh */
`ifndef DSP_PARAMS_SVH
`define DSP_PARAMS_SVH

//////////////////////////////
// widths and depths
`define DSP_WORD_W      16
`define DSP_INSN_W      24
`define DSP_PC_W        11
`define DSP_STACK_DEPTH 16
`define DSP_RAM_AW      8

//////////////////////////////
// status register bits
`define DSP_SR_RQM 15
`define DSP_SR_DRS 12

//////////////////////////////
// instruction classes, opcode bits 23:22
`define DSP_CLS_OP 2'd0
`define DSP_CLS_RT 2'd1
`define DSP_CLS_JP 2'd2
`define DSP_CLS_LD 2'd3

`define DSP_DST_DR 4'b0110
`define DSP_SRC_DR 4'b1000

`endif
